//--- rtl/ptw_defines.svh
// Sv32 width and level macros, included by the packages and by modules that slice addresses
`ifndef PTW_DEFINES_SVH
`define PTW_DEFINES_SVH

// ----------------------------------------
// address widths
// ----------------------------------------
// virtual address
`define PTW_VLEN 32
// physical address, 22-bit ppn plus page offset
`define PTW_PLEN 34
// physical page number
`define PTW_PPN_W 22

// ----------------------------------------
// page-table geometry
// ----------------------------------------
// one vpn field indexes a 1024-entry table
`define PTW_VPN_W 10
// root table and leaf table
`define PTW_LEVELS 2
// 4 KiB pages
`define PTW_PGOFF_W 12
// one pte is a 32-bit word
`define PTW_PTE_BYTES 4
// address-space id from satp
`define PTW_ASID_W 9

`endif

//--- rtl/ptw_sv32_pkg.sv
// Sv32 address, page-number and page-table-entry types, imported by the walker and its testbench
`default_nettype none

`include "ptw_defines.svh"

package ptw_sv32_pkg;

  // ----------------------------------------
  // addresses and page numbers
  // ----------------------------------------
  typedef logic [`PTW_VLEN-1:0] vaddr_t;
  typedef logic [`PTW_PLEN-1:0] paddr_t;
  typedef logic [`PTW_PPN_W-1:0] ppn_t;
  // a single vpn field, vpn[1] or vpn[0]
  typedef logic [`PTW_VPN_W-1:0] vpn_t;
  typedef logic [`PTW_ASID_W-1:0] asid_t;

  // walk depth, 0 is the root table
  typedef logic [$clog2(`PTW_LEVELS)-1:0] level_t;

  // ----------------------------------------
  // page-table entry, msb first
  // ----------------------------------------
  typedef struct packed {
    ppn_t       ppn;
    // reserved for supervisor software
    logic [1:0] rsw;
    logic       d;
    logic       a;
    logic       g;
    logic       u;
    logic       x;
    logic       w;
    logic       r;
    logic       v;
  } pte_t;

endpackage

`default_nettype wire

//--- rtl/ptw_bus_pkg.sv
// structs and enums exchanged between the walker, the shared TLB and the memory port
`default_nettype none

`include "ptw_defines.svh"

package ptw_bus_pkg;

  // kind of access that missed, selects the permission rule
  typedef enum logic [1:0] {
    ACC_FETCH,
    ACC_LOAD,
    ACC_STORE
  } access_e;

  // walker FSM states
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GRANT,
    PTE_LOOKUP,
    PROPAGATE_ERROR,
    WAIT_RVALID,
    LATENCY
  } walk_state_e;

  // outcome of checking one fetched entry
  typedef enum logic [1:0] {
    PTE_LEAF,
    PTE_POINTER,
    PTE_FAULT
  } pte_verdict_e;

  // ----------------------------------------
  // TLB side
  // ----------------------------------------
  typedef struct packed {
    logic                  valid;
    ptw_sv32_pkg::vaddr_t  vaddr;
    access_e               access;
    ptw_sv32_pkg::asid_t   asid;
  } walk_req_t;

  typedef struct packed {
    logic                                  valid;
    logic [`PTW_LEVELS*`PTW_VPN_W-1:0]     vpn;
    ptw_sv32_pkg::asid_t                   asid;
    // set for a 4 MiB leaf found in the root table
    logic                                  superpage;
    ptw_sv32_pkg::pte_t                    pte;
  } tlb_update_t;

  // ----------------------------------------
  // memory side
  // ----------------------------------------
  typedef struct packed {
    logic                  req;
    ptw_sv32_pkg::paddr_t  addr;
  } mem_req_t;

  typedef struct packed {
    logic                          gnt;
    logic                          rvalid;
    logic [`PTW_PTE_BYTES*8-1:0]   rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

//--- rtl/ptw_mem_port.sv
// read-only memory port of the walker: request/grant handshake, registered response, pending flag
`timescale 1ns/1ps
`default_nettype none

module ptw_mem_port (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   issue_i,
  input  ptw_sv32_pkg::paddr_t   addr_i,
  input  ptw_bus_pkg::mem_rsp_t  mem_rsp_i,
  output ptw_bus_pkg::mem_req_t  mem_req_o,
  output logic                   granted_o,
  output logic                   pte_valid_o,
  output ptw_sv32_pkg::pte_t     pte_o,
  output logic                   pending_o
);

  import ptw_sv32_pkg::*;

  logic rvalid_q;
  pte_t rdata_q;
  // a granted read whose rvalid has not yet arrived
  logic pending_q;

  // request follows the FSM directly, addr comes from the pointer register
  assign mem_req_o.req  = issue_i;
  assign mem_req_o.addr = addr_i;

  // a grant only counts while we are asking
  assign granted_o = issue_i & mem_rsp_i.gnt;

  // ----------------------------------------
  // response registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q  <= 1'b0;
      pending_q <= 1'b0;
    end else begin
      rvalid_q <= mem_rsp_i.rvalid;
      // one read at a time, so grant and rvalid never coincide
      if (granted_o) begin
        pending_q <= 1'b1;
      end else if (mem_rsp_i.rvalid) begin
        pending_q <= 1'b0;
      end
    end
  end

  // returned word, only sampled when it is valid
  always_ff @(posedge clk_i) begin
    if (mem_rsp_i.rvalid) begin
      rdata_q <= pte_t'(mem_rsp_i.rdata);
    end
  end

  assign pte_valid_o = rvalid_q;
  assign pte_o       = rdata_q;
  assign pending_o   = pending_q;

endmodule

`default_nettype wire

//--- rtl/ptw_pte_check.sv
// combinational Sv32 entry checker, classifies a fetched PTE as leaf, pointer or page fault
`timescale 1ns/1ps
`default_nettype none

`include "ptw_defines.svh"

module ptw_pte_check (
  input  ptw_sv32_pkg::pte_t          pte_i,
  input  ptw_sv32_pkg::level_t        level_i,
  input  ptw_bus_pkg::access_e        access_i,
  input  logic                        mxr_i,
  output ptw_bus_pkg::pte_verdict_e   verdict_o
);

  import ptw_sv32_pkg::*;
  import ptw_bus_pkg::*;

  // deepest table, a pointer here has nowhere to go
  localparam level_t LastLevel = level_t'(`PTW_LEVELS - 1);

  logic bad_encoding;
  logic is_pointer;
  logic misaligned;
  logic load_ok;
  logic perm_ok;

  // v=0, or write without read, is reserved
  assign bad_encoding = !pte_i.v || (pte_i.w && !pte_i.r);

  // no r and no x means next-level table
  assign is_pointer = !pte_i.r && !pte_i.x;

  // a root-table leaf maps 4 MiB, low ppn field must be clear
  assign misaligned = (level_i == level_t'(0)) && (pte_i.ppn[`PTW_VPN_W-1:0] != '0);

  // readable, or executable with make-executable-readable
  assign load_ok = pte_i.a && (pte_i.r || (pte_i.x && mxr_i));

  // ----------------------------------------
  // permission and accessed/dirty rules
  // ----------------------------------------
  always_comb begin
    case (access_i)
      ACC_FETCH: perm_ok = pte_i.x && pte_i.a;
      ACC_LOAD:  perm_ok = load_ok;
      ACC_STORE: perm_ok = load_ok && pte_i.w && pte_i.d;
      default:   perm_ok = 1'b0;
    endcase
  end

  // checks in priority order
  always_comb begin
    if (bad_encoding) begin
      verdict_o = PTE_FAULT;
    end else if (is_pointer) begin
      verdict_o = (level_i == LastLevel) ? PTE_FAULT : PTE_POINTER;
    end else if (misaligned) begin
      verdict_o = PTE_FAULT;
    end else if (perm_ok) begin
      verdict_o = PTE_LEAF;
    end else begin
      verdict_o = PTE_FAULT;
    end
  end

endmodule

`default_nettype wire

//--- rtl/ptw_walk_fsm.sv
// walker FSM: latches a TLB miss, steps through the two Sv32 levels, emits TLB fills or faults
`timescale 1ns/1ps
`default_nettype none

`include "ptw_defines.svh"

module ptw_walk_fsm (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  ptw_bus_pkg::walk_req_t       walk_req_i,
  input  ptw_sv32_pkg::ppn_t           satp_ppn_i,
  input  logic                         granted_i,
  input  logic                         pte_valid_i,
  input  logic                         pending_i,
  input  ptw_sv32_pkg::pte_t           pte_i,
  input  ptw_bus_pkg::pte_verdict_e    verdict_i,
  output logic                         issue_o,
  output ptw_sv32_pkg::paddr_t         addr_o,
  output ptw_sv32_pkg::level_t         level_o,
  output ptw_bus_pkg::access_e         access_o,
  output logic                         busy_o,
  output ptw_bus_pkg::tlb_update_t     update_o,
  output logic                         fault_o
);

  import ptw_sv32_pkg::*;
  import ptw_bus_pkg::*;

  // byte offset of a pte inside its table
  localparam int unsigned PteOffW = $clog2(`PTW_PTE_BYTES);

  walk_state_e state_q, state_d;
  level_t      level_q, level_d;
  logic        global_q, global_d;
  // payload of the walk in flight
  vaddr_t      vaddr_q;
  asid_t       asid_q;
  access_e     access_q;
  paddr_t      pptr_q, pptr_d;
  logic        accept;
  logic        leaf_hit;
  pte_t        fill_pte;

  // table base times page size plus index times pte size
  function automatic paddr_t pte_addr(input ppn_t base, input vpn_t idx);
    return {base, idx, {PteOffW{1'b0}}};
  endfunction

  // a new miss is only taken when idle and not being flushed
  assign accept   = (state_q == IDLE) && walk_req_i.valid && !flush_i;
  assign leaf_hit = (state_q == PTE_LOOKUP) && pte_valid_i && (verdict_i == PTE_LEAF);

  // ----------------------------------------
  // next state
  // ----------------------------------------
  always_comb begin
    state_d  = state_q;
    level_d  = level_q;
    global_d = global_q;
    pptr_d   = pptr_q;
    case (state_q)
      IDLE: begin
        level_d  = '0;
        global_d = 1'b0;
        if (accept) begin
          // root entry indexed by vpn[1]
          pptr_d  = pte_addr(satp_ppn_i, walk_req_i.vaddr[`PTW_VLEN-1 -: `PTW_VPN_W]);
          state_d = WAIT_GRANT;
        end
      end
      WAIT_GRANT: begin
        if (granted_i) begin
          state_d = PTE_LOOKUP;
        end
      end
      PTE_LOOKUP: begin
        if (pte_valid_i) begin
          // g of every entry on the path counts
          global_d = global_q | pte_i.g;
          case (verdict_i)
            PTE_LEAF: state_d = LATENCY;
            PTE_POINTER: begin
              level_d = level_t'(level_q + 1'b1);
              // leaf table indexed by vpn[0]
              pptr_d  = pte_addr(pte_i.ppn, vaddr_q[`PTW_PGOFF_W +: `PTW_VPN_W]);
              state_d = WAIT_GRANT;
            end
            default: state_d = PROPAGATE_ERROR;
          endcase
        end
      end
      PROPAGATE_ERROR: state_d = LATENCY;
      // a flushed read still has to come back before the port is free
      WAIT_RVALID: begin
        if (pte_valid_i) begin
          state_d = IDLE;
        end
      end
      LATENCY: state_d = IDLE;
      default: state_d = IDLE;
    endcase

    // flush aborts any walk, draining a granted read first
    if (flush_i && (state_q != IDLE)) begin
      state_d = (pending_i || granted_i) ? WAIT_RVALID : LATENCY;
    end
  end

  // ----------------------------------------
  // registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      level_q  <= '0;
      global_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      level_q  <= level_d;
      global_q <= global_d;
    end
  end

  always_ff @(posedge clk_i) begin
    pptr_q <= pptr_d;
    if (accept) begin
      vaddr_q  <= walk_req_i.vaddr;
      asid_q   <= walk_req_i.asid;
      access_q <= walk_req_i.access;
    end
  end

  // leaf with the accumulated global bit
  always_comb begin
    fill_pte   = pte_i;
    fill_pte.g = global_q | pte_i.g;
  end

  assign issue_o  = (state_q == WAIT_GRANT);
  assign addr_o   = pptr_q;
  assign level_o  = level_q;
  assign access_o = access_q;
  assign busy_o   = (state_q != IDLE);

  // update and fault are one-cycle pulses, dropped under flush
  assign update_o.valid     = leaf_hit && !flush_i;
  assign update_o.vpn       = vaddr_q[`PTW_VLEN-1:`PTW_PGOFF_W];
  assign update_o.asid      = asid_q;
  assign update_o.superpage = (level_q == level_t'(0));
  assign update_o.pte       = fill_pte;
  assign fault_o            = (state_q == PROPAGATE_ERROR) && !flush_i;

endmodule

`default_nettype wire

//--- rtl/ptw_top.sv
// Sv32 page-table walker top level, joins memory port, entry checker and walk FSM
`timescale 1ns/1ps
`default_nettype none

module ptw_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  ptw_bus_pkg::walk_req_t     walk_req_i,
  input  ptw_sv32_pkg::ppn_t         satp_ppn_i,
  input  logic                       mxr_i,
  input  ptw_bus_pkg::mem_rsp_t      mem_rsp_i,
  output ptw_bus_pkg::mem_req_t      mem_req_o,
  output logic                       busy_o,
  output ptw_bus_pkg::tlb_update_t   update_o,
  output logic                       fault_o
);

  import ptw_sv32_pkg::*;
  import ptw_bus_pkg::*;

  // FSM to memory port
  logic         issue;
  paddr_t       addr;
  // memory port back to FSM
  logic         granted;
  logic         pte_valid;
  logic         pending;
  pte_t         pte;
  // checker inputs and result
  level_t       level;
  access_e      access;
  pte_verdict_e verdict;

  ptw_mem_port u_mem_port (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .issue_i     (issue),
    .addr_i      (addr),
    .mem_rsp_i   (mem_rsp_i),
    .mem_req_o   (mem_req_o),
    .granted_o   (granted),
    .pte_valid_o (pte_valid),
    .pte_o       (pte),
    .pending_o   (pending)
  );

  ptw_pte_check u_pte_check (
    .pte_i     (pte),
    .level_i   (level),
    .access_i  (access),
    .mxr_i     (mxr_i),
    .verdict_o (verdict)
  );

  ptw_walk_fsm u_walk_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .walk_req_i  (walk_req_i),
    .satp_ppn_i  (satp_ppn_i),
    .granted_i   (granted),
    .pte_valid_i (pte_valid),
    .pending_i   (pending),
    .pte_i       (pte),
    .verdict_i   (verdict),
    .issue_o     (issue),
    .addr_o      (addr),
    .level_o     (level),
    .access_o    (access),
    .busy_o      (busy_o),
    .update_o    (update_o),
    .fault_o     (fault_o)
  );

endmodule

`default_nettype wire

//--- sim/ptw_properties.sv
// handshake assertions for the page-table walker, bound onto the top level from the testbench
`timescale 1ns/1ps
`default_nettype none

module ptw_properties (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      flush_i,
  input ptw_bus_pkg::mem_req_t     mem_req_i,
  input ptw_bus_pkg::mem_rsp_t     mem_rsp_i,
  input logic                      busy_i,
  input ptw_bus_pkg::tlb_update_t  update_i,
  input logic                      fault_i
);

  // a walk ends in exactly one way
  a_update_xor_fault: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(update_i.valid && fault_i))
    else $error("update and fault raised in the same cycle");

  // request holds until granted, a flush may withdraw it
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_i.req && !mem_rsp_i.gnt && !flush_i) |=>
      (mem_req_i.req && $stable(mem_req_i.addr)))
    else $error("memory request dropped or changed before grant");

  // no memory traffic from an idle walker
  a_req_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i.req |-> busy_i)
    else $error("memory request while walker not busy");

endmodule

bind ptw_top ptw_properties u_ptw_properties (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .flush_i   (flush_i),
  .mem_req_i (mem_req_o),
  .mem_rsp_i (mem_rsp_i),
  .busy_i    (busy_o),
  .update_i  (update_o),
  .fault_i   (fault_o)
);

`default_nettype wire

//--- sim/ptw_tb.sv
// testbench for the Sv32 walker: page-table memory model, reference walk, directed misses, checks
`timescale 1ns/1ps
`default_nettype none

`include "ptw_defines.svh"

module ptw_tb;

  import ptw_sv32_pkg::*;
  import ptw_bus_pkg::*;

  localparam int NumTests = 14;
  // pte flag bits, v in bit 0
  localparam logic [7:0] FlagV = 8'h01;
  localparam logic [7:0] FlagR = 8'h02;
  localparam logic [7:0] FlagW = 8'h04;
  localparam logic [7:0] FlagX = 8'h08;
  localparam logic [7:0] FlagG = 8'h20;
  localparam logic [7:0] FlagA = 8'h40;
  localparam logic [7:0] FlagD = 8'h80;
  // root and leaf table page numbers
  localparam ppn_t RootPpn = 22'h00100;
  localparam ppn_t TableA  = 22'h00200;
  localparam ppn_t TableB  = 22'h00300;

  // expected outcome of one walk
  typedef struct packed {
    logic        fault;
    logic        superpage;
    logic [19:0] vpn;
    asid_t       asid;
    pte_t        pte;
  } exp_t;

  logic        clk;
  logic        rst_n;
  logic        flush;
  walk_req_t   walk_req;
  ppn_t        satp_ppn;
  logic        mxr;
  mem_rsp_t    mem_rsp;
  mem_req_t    mem_req;
  logic        busy;
  tlb_update_t update;
  logic        fault;

  logic [31:0] mem_words [paddr_t];
  exp_t        exp_q[$];
  int          errors   = 0;
  int          test_num = 0;
  integer      seed     = 32'h9894_935c;

  ptw_top u_ptw_top (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .flush_i    (flush),
    .walk_req_i (walk_req),
    .satp_ppn_i (satp_ppn),
    .mxr_i      (mxr),
    .mem_rsp_i  (mem_rsp),
    .mem_req_o  (mem_req),
    .busy_o     (busy),
    .update_o   (update),
    .fault_o    (fault)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------
  // helpers and reference walk
  // ----------------------------------------
  function automatic pte_t make_pte(input ppn_t ppn, input logic [7:0] flags);
    return pte_t'({ppn, 2'b00, flags});
  endfunction

  // table base times page size plus index times pte size
  function automatic paddr_t entry_addr(input ppn_t base, input vpn_t idx);
    return paddr_t'(base) * 4096 + paddr_t'(idx) * 4;
  endfunction

  // unmapped words read as zero, an invalid pte
  function automatic logic [31:0] read_word(input paddr_t a);
    if (mem_words.exists(a)) begin
      return mem_words[a];
    end
    return 32'h0;
  endfunction

  function automatic exp_t walk_ref(input vaddr_t va, input access_e acc, input asid_t asid,
                                    input ppn_t root, input logic mxr_bit);
    exp_t   res;
    pte_t   pte;
    paddr_t a;
    logic   g;
    logic   ok;
    int     lvl;
    res       = '0;
    res.fault = 1'b1;
    res.vpn   = va[31:12];
    res.asid  = asid;
    g         = 1'b0;
    a         = entry_addr(root, va[31:22]);
    for (lvl = 0; lvl < `PTW_LEVELS; lvl++) begin
      pte = pte_t'(read_word(a));
      g   = g | pte.g;
      if (!pte.v || (pte.w && !pte.r)) begin
        return res;
      end
      if (!pte.r && !pte.x) begin
        // pointer, only legal above the last level
        if (lvl == `PTW_LEVELS - 1) begin
          return res;
        end
        a = entry_addr(pte.ppn, va[21:12]);
      end else begin
        // superpage needs its low ppn field clear
        if (lvl == 0 && pte.ppn[9:0] != 10'h0) begin
          return res;
        end
        case (acc)
          ACC_FETCH: ok = pte.x && pte.a;
          ACC_LOAD:  ok = pte.a && (pte.r || (pte.x && mxr_bit));
          default:   ok = pte.a && (pte.r || (pte.x && mxr_bit)) && pte.w && pte.d;
        endcase
        if (ok) begin
          res.fault     = 1'b0;
          res.pte       = pte;
          res.pte.g     = g;
          res.superpage = (lvl == 0);
        end
        return res;
      end
    end
    return res;
  endfunction

  // ----------------------------------------
  // memory model, random grant and response delay
  // ----------------------------------------
  initial begin : mem_model
    int     gnt_wait;
    int     rsp_wait;
    paddr_t rd_addr;
    mem_rsp = '0;
    forever begin
      @(posedge clk);
      #2;
      if (mem_req.req) begin
        gnt_wait = $unsigned($random(seed)) % 4;
        while (gnt_wait > 0 && mem_req.req) begin
          gnt_wait--;
          @(posedge clk);
          #2;
        end
        // request may have been withdrawn by a flush
        if (mem_req.req) begin
          mem_rsp.gnt = 1'b1;
          rd_addr     = mem_req.addr;
          rsp_wait    = 1 + $unsigned($random(seed)) % 3;
          @(posedge clk);
          #2;
          mem_rsp.gnt = 1'b0;
          repeat (rsp_wait - 1) begin
            @(posedge clk);
            #2;
          end
          mem_rsp.rvalid = 1'b1;
          mem_rsp.rdata  = read_word(rd_addr);
          @(posedge clk);
          #2;
          mem_rsp.rvalid = 1'b0;
          mem_rsp.rdata  = '0;
        end
      end
    end
  end

  // ----------------------------------------
  // compare, sampled mid-cycle
  // ----------------------------------------
  always @(negedge clk) begin : compare
    exp_t want;
    if (rst_n && (update.valid || fault)) begin
      assert (exp_q.size() != 0) else begin
        $display("walker reported a result with no walk expecting one, at %0t ns", $time);
        errors++;
      end
      if (exp_q.size() != 0) begin
        want = exp_q.pop_front();
        assert (fault == want.fault && update.valid == !want.fault) else begin
          $display("[ERROR] %0t: update=%0b fault=%0b, expected fault=%0b",
                   $time, update.valid, fault, want.fault);
          errors++;
        end
        if (!want.fault && update.valid) begin
          assert (update.pte == want.pte && update.superpage == want.superpage &&
                  update.vpn == want.vpn && update.asid == want.asid) else begin
            $display("[ERROR] %0t: pte=%h sp=%0b vpn=%h asid=%h, expected %h %0b %h %h",
                     $time, update.pte, update.superpage, update.vpn, update.asid,
                     want.pte, want.superpage, want.vpn, want.asid);
            errors++;
          end
        end
      end
    end
  end

  // one miss, optionally flushed two cycles in
  task automatic run_walk(input string name, input vpn_t vpn1, input vpn_t vpn0,
                          input access_e acc, input logic mxr_bit, input logic do_flush);
    int     err_before;
    vaddr_t va;
    err_before = errors;
    test_num++;
    va  = vaddr_t'({vpn1, vpn0, 12'h5a4});
    mxr = mxr_bit;
    if (!do_flush) begin
      exp_q.push_back(walk_ref(va, acc, asid_t'(test_num), satp_ppn, mxr_bit));
    end
    walk_req.valid  = 1'b1;
    walk_req.vaddr  = va;
    walk_req.access = acc;
    walk_req.asid   = asid_t'(test_num);
    @(posedge clk);
    #2;
    walk_req.valid = 1'b0;
    if (do_flush) begin
      @(posedge clk);
      #2;
      flush = 1'b1;
      @(posedge clk);
      #2;
      flush = 1'b0;
    end
    // busy must fall, the watchdog catches a stuck walker
    while (busy) begin
      @(posedge clk);
      #2;
    end
    assert (exp_q.size() == 0) else begin
      $display("walk %0d finished without an update or fault", test_num);
      errors++;
    end
    exp_q.delete();
    $display("test %0d %s: %s", test_num, name, (errors == err_before) ? "pass" : "fail");
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin
    rst_n    = 1'b0;
    flush    = 1'b0;
    walk_req = '0;
    satp_ppn = RootPpn;
    mxr      = 1'b0;
    mem_words[entry_addr(RootPpn, 10'd1)] = make_pte(TableA, FlagV);
    mem_words[entry_addr(RootPpn, 10'd2)] = make_pte(22'h00400, FlagV | FlagX | FlagA);
    mem_words[entry_addr(RootPpn, 10'd3)] = make_pte(22'h00401, FlagV | FlagX | FlagA);
    mem_words[entry_addr(RootPpn, 10'd4)] = make_pte(TableB, FlagV | FlagG);
    mem_words[entry_addr(TableA, 10'd1)]  = make_pte(22'h12345, FlagV | FlagR | FlagA);
    mem_words[entry_addr(TableA, 10'd2)]  = make_pte(22'h12346, FlagV | FlagR | FlagW | FlagA);
    mem_words[entry_addr(TableA, 10'd3)]  = make_pte(22'h12347, FlagV | FlagX | FlagA);
    mem_words[entry_addr(TableA, 10'd4)]  = make_pte(22'h12348, FlagR | FlagA);
    mem_words[entry_addr(TableA, 10'd5)]  = make_pte(22'h12349, FlagV | FlagW | FlagA);
    mem_words[entry_addr(TableA, 10'd6)]  = make_pte(22'h00500, FlagV);
    mem_words[entry_addr(TableA, 10'd8)]  =
      make_pte(22'h1234a, FlagV | FlagR | FlagW | FlagA | FlagD);
    mem_words[entry_addr(TableB, 10'd7)]  = make_pte(22'h05555, FlagV | FlagR | FlagA);
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    run_walk("load 4k page", 10'd1, 10'd1, ACC_LOAD, 1'b0, 1'b0);
    run_walk("fetch superpage", 10'd2, 10'd9, ACC_FETCH, 1'b0, 1'b0);
    run_walk("fetch misaligned superpage", 10'd3, 10'd9, ACC_FETCH, 1'b0, 1'b0);
    run_walk("store with d clear", 10'd1, 10'd2, ACC_STORE, 1'b1, 1'b0);
    run_walk("fetch with x clear", 10'd1, 10'd1, ACC_FETCH, 1'b1, 1'b0);
    run_walk("load x-only, mxr low", 10'd1, 10'd3, ACC_LOAD, 1'b0, 1'b0);
    run_walk("load x-only, mxr high", 10'd1, 10'd3, ACC_LOAD, 1'b1, 1'b0);
    run_walk("invalid pte", 10'd1, 10'd4, ACC_LOAD, 1'b0, 1'b0);
    run_walk("write without read", 10'd1, 10'd5, ACC_LOAD, 1'b0, 1'b0);
    run_walk("pointer at last level", 10'd1, 10'd6, ACC_LOAD, 1'b0, 1'b0);
    run_walk("store with d set", 10'd1, 10'd8, ACC_STORE, 1'b0, 1'b0);
    run_walk("global root pointer", 10'd4, 10'd7, ACC_LOAD, 1'b0, 1'b0);
    run_walk("flush mid-walk", 10'd1, 10'd1, ACC_LOAD, 1'b0, 1'b1);
    run_walk("load after flush", 10'd1, 10'd1, ACC_LOAD, 1'b0, 1'b0);
    $display("tests run %0d, errors %0d", test_num, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // forty cycles per test plus reset
  initial begin
    #((NumTests + 1) * 40 * 40);
    $display("timeout: the walks did not finish in the expected time");
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+rtl
rtl/ptw_sv32_pkg.sv
rtl/ptw_bus_pkg.sv
rtl/ptw_mem_port.sv
rtl/ptw_pte_check.sv
rtl/ptw_walk_fsm.sv
rtl/ptw_top.sv
sim/ptw_properties.sv
sim/ptw_tb.sv
